//--- logic/cache_pkg.sv
package cache_pkg;

  localparam int addr_width = 16;
  // one LRU bit per set only covers two ways
  localparam int num_ways = 2;

  // the field view below is sized for this set count
  localparam int default_sets = 8;
  localparam int offset_width = 3;
  localparam int index_width = $clog2(default_sets);
  localparam int tag_width = addr_width - index_width - offset_width;
  localparam int word_addr_width = addr_width - offset_width;

  typedef struct packed {
    logic [tag_width-1:0]    tag;
    logic [index_width-1:0]  index;
    logic [offset_width-1:0] offset;
  } addr_fields_t;

  // flat byte address for requesters, split fields for the array
  typedef union packed {
    logic [addr_width-1:0] raw;
    addr_fields_t          f;
  } cache_addr_u;

  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [tag_width-1:0] tag;
    logic [63:0]          data;
  } cache_line_t;

  typedef struct packed {
    logic                       rd_en;
    logic [word_addr_width-1:0] addr;
  } load_req_t;

  typedef struct packed {
    logic                       wr_en;
    logic [word_addr_width-1:0] addr;
    logic [63:0]                value;
  } store_req_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] value;
  } load_resp_t;

  typedef enum logic [1:0] {
    miss_load,
    miss_store,
    miss_evict
  } miss_kind_e;

  // slot positions in one push, also the order they enter the queue
  localparam int slot_load = 0;
  localparam int slot_store = 1;
  localparam int slot_evict = 2;
  localparam int num_slots = 3;

  typedef struct packed {
    logic        en;
    miss_kind_e  kind;
    cache_addr_u addr;
    logic [63:0] data;
    logic        dirty;
  } miss_slot_t;

  typedef struct packed {
    miss_slot_t [num_slots-1:0] slot;
  } miss_req_t;

  typedef struct packed {
    logic        en;
    cache_addr_u addr;
    logic [63:0] data;
    logic        dirty;
  } fill_t;

endpackage

//--- logic/mem_bus_pkg.sv
package mem_bus_pkg;

  localparam int bus_addr_width = 16;
  localparam int bus_tag_width = 4;

  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_cmd_e;

  typedef struct packed {
    bus_cmd_e                  command;
    logic [bus_addr_width-1:0] addr;
    logic [63:0]               data;
  } mem_req_t;

  // response 0 means refused, data_tag 0 means no data this cycle
  typedef struct packed {
    logic [bus_tag_width-1:0] response;
    logic [bus_tag_width-1:0] data_tag;
    logic [63:0]              data;
  } mem_resp_t;

endpackage

//--- logic/dcache_array.sv
`timescale 1ns/10ps

module dcache_array
  import cache_pkg::*;
#(
  parameter int num_sets = 8
) (
  input  logic                                clock,
  input  logic                                reset,
  input  cache_addr_u                         rd_addr,
  input  logic                                rd_search,
  output logic                                rd_hit,
  output logic [63:0]                         rd_data,
  input  cache_addr_u                         wr_addr,
  input  logic                                wr_search,
  input  logic                                wr_en,
  input  logic                                wr_from_fill,
  input  logic                                wr_dirty,
  input  logic                                wr_valid,
  input  logic [63:0]                         wr_data,
  output logic                                wr_hit,
  input  logic [$clog2(num_sets*num_ways)-1:0] sweep_slot,
  output cache_line_t                         sweep_line,
  output cache_line_t                         victim
);

  localparam int set_bits = $clog2(num_sets);

  logic [tag_width-1:0] tags [num_sets][num_ways];
  logic [63:0]          words [num_sets][num_ways];
  logic [num_ways-1:0]  valid_bits [num_sets];
  logic [num_ways-1:0]  dirty_bits [num_sets];
  // way to replace next in each set
  logic [num_sets-1:0]  lru;

  logic [num_ways-1:0]  rd_match;
  logic [num_ways-1:0]  wr_match;
  logic [set_bits-1:0]  rd_set;
  logic [set_bits-1:0]  wr_set;
  logic [set_bits-1:0]  sweep_set;
  logic                 rd_way;
  logic                 wr_way;
  logic                 victim_way;
  logic                 sweep_way;

  assign rd_set = rd_addr.f.index;
  assign wr_set = wr_addr.f.index;
  // sweep walks way-minor
  assign sweep_set = sweep_slot[set_bits:1];
  assign sweep_way = sweep_slot[0];

  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      rd_match[w] = valid_bits[rd_set][w] && (tags[rd_set][w] == rd_addr.f.tag);
      wr_match[w] = valid_bits[wr_set][w] && (tags[wr_set][w] == wr_addr.f.tag);
    end
  end

  assign rd_way = rd_match[1];
  assign wr_way = wr_match[1];
  assign rd_hit = rd_search && (|rd_match);
  assign rd_data = words[rd_set][rd_way];
  assign wr_hit = wr_search && (|wr_match);

  // empty way first, otherwise the LRU way
  assign victim_way = !valid_bits[wr_set][0] ? 1'b0 :
                      !valid_bits[wr_set][1] ? 1'b1 : lru[wr_set];

  assign victim.valid = valid_bits[wr_set][victim_way];
  assign victim.dirty = dirty_bits[wr_set][victim_way];
  assign victim.tag = tags[wr_set][victim_way];
  assign victim.data = words[wr_set][victim_way];

  assign sweep_line.valid = valid_bits[sweep_set][sweep_way];
  assign sweep_line.dirty = dirty_bits[sweep_set][sweep_way];
  assign sweep_line.tag = tags[sweep_set][sweep_way];
  assign sweep_line.data = words[sweep_set][sweep_way];

  // tag and data storage
  always_ff @(posedge clock) begin
    if (wr_en && wr_hit) begin
      // a clean fill never overwrites a line that is already present
      if (!wr_from_fill || wr_dirty) begin
        words[wr_set][wr_way] <= wr_data;
      end
    end else if (wr_en && wr_search && wr_from_fill) begin
      words[wr_set][victim_way] <= wr_data;
      tags[wr_set][victim_way] <= wr_addr.f.tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < num_sets; s++) begin
        valid_bits[s] <= '0;
        dirty_bits[s] <= '0;
      end
      lru <= '0;
    end else begin
      if (rd_hit) begin
        lru[rd_set] <= !rd_way;
      end
      if (wr_en && !wr_search) begin
        // sweep write, line stays in place
        valid_bits[sweep_set][sweep_way] <= wr_valid;
        dirty_bits[sweep_set][sweep_way] <= wr_dirty;
      end else if (wr_en && wr_hit) begin
        dirty_bits[wr_set][wr_way] <= dirty_bits[wr_set][wr_way] | wr_dirty;
        lru[wr_set] <= !wr_way;
      end else if (wr_en && wr_from_fill) begin
        valid_bits[wr_set][victim_way] <= wr_valid;
        dirty_bits[wr_set][victim_way] <= wr_dirty;
        lru[wr_set] <= !victim_way;
      end
    end
  end

endmodule

//--- logic/flush_counter.sv
`timescale 1ns/10ps

module flush_counter
  import cache_pkg::*;
#(
  parameter int num_sets = 8
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                start,
  input  logic                                step,
  output logic [$clog2(num_sets*num_ways)-1:0] slot,
  output logic                                last
);

  localparam int slot_bits = $clog2(num_sets * num_ways);
  localparam logic [slot_bits-1:0] last_slot = slot_bits'(num_sets * num_ways - 1);

  // way in bit 0, set above it
  always_ff @(posedge clock) begin
    if (reset || start) begin
      slot <= '0;
    end else if (step) begin
      slot <= slot + 1'b1;
    end
  end

  assign last = (slot == last_slot);

endmodule

//--- logic/flush_sequencer.sv
`timescale 1ns/10ps

module flush_sequencer (
  input  logic clock,
  input  logic reset,
  input  logic write_back,
  input  logic queue_empty,
  input  logic sweep_last,
  input  logic sweep_step,
  output logic sweeping,
  output logic halt_pipeline
);

  typedef enum logic [1:0] {
    st_idle,
    st_drain,
    st_sweep,
    st_done
  } state_e;

  state_e state;
  state_e next_state;

  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (write_back) begin
          next_state = st_drain;
        end
      end
      st_drain: begin
        // outstanding misses finish before the sweep starts
        if (queue_empty) begin
          next_state = st_sweep;
        end
      end
      st_sweep: begin
        if (sweep_step && sweep_last) begin
          next_state = st_done;
        end
      end
      default: next_state = st_done;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  assign sweeping = (state == st_sweep);
  assign halt_pipeline = (state == st_done) && queue_empty;

endmodule

//--- logic/miss_queue.sv
`timescale 1ns/10ps

module miss_queue
  import cache_pkg::*, mem_bus_pkg::*;
#(
  parameter int miss_depth = 4
) (
  input  logic      clock,
  input  logic      reset,
  input  miss_req_t miss_req,
  output logic      queue_ready,
  output logic      queue_empty,
  output fill_t     fill,
  input  logic      fill_taken,
  output mem_req_t  mem_req,
  input  mem_resp_t mem_resp
);

  // power-of-two depth, pointers wrap by themselves
  localparam int ptr_width = $clog2(miss_depth);

  typedef struct packed {
    miss_kind_e               kind;
    cache_addr_u              addr;
    logic [63:0]              data;
    logic                     dirty;
    logic [bus_tag_width-1:0] tag;
  } entry_t;

  entry_t                entries [miss_depth];
  logic [miss_depth-1:0] busy;
  logic [miss_depth-1:0] issued;
  logic [miss_depth-1:0] returned;
  logic [miss_depth-1:0] data_match;
  logic [ptr_width-1:0]  head;
  logic [ptr_width-1:0]  issue;
  logic [ptr_width-1:0]  tail;
  logic [ptr_width-1:0]  slot_ptr [num_slots];
  logic [1:0]            push_count;
  logic                  issue_valid;
  logic                  accepted;
  logic                  retire;
  entry_t                head_entry;
  entry_t                issue_entry;

  // enabled slots land at consecutive entries from tail
  always_comb begin
    push_count = '0;
    for (int k = 0; k < num_slots; k++) begin
      slot_ptr[k] = tail + ptr_width'(push_count);
      if (miss_req.slot[k].en) begin
        push_count = push_count + 2'd1;
      end
    end
  end

  // room for a full push, counting the one already on its way in
  assign queue_ready = ($countones(busy) + int'(push_count) + num_slots) <= miss_depth;
  assign queue_empty = (busy == '0) && (push_count == '0);

  assign head_entry = entries[head];
  assign issue_entry = entries[issue];

  assign issue_valid = busy[issue] && !issued[issue];
  assign accepted = issue_valid && (mem_resp.response != '0);

  assign mem_req.command = !issue_valid ? bus_none :
                           (issue_entry.kind == miss_evict) ? bus_store : bus_load;
  assign mem_req.addr = issue_entry.addr.raw;
  assign mem_req.data = issue_entry.data;

  always_comb begin
    for (int i = 0; i < miss_depth; i++) begin
      data_match[i] = busy[i] && issued[i] && !returned[i] &&
                      (entries[i].kind != miss_evict) &&
                      (mem_resp.data_tag != '0) && (mem_resp.data_tag == entries[i].tag);
    end
  end

  // fills leave in queue order from head
  assign fill.en = busy[head] && returned[head];
  assign fill.addr = head_entry.addr;
  assign fill.data = head_entry.data;
  assign fill.dirty = head_entry.dirty;

  // evicts are done once memory takes them
  assign retire = busy[head] && ((head_entry.kind == miss_evict) ? issued[head] :
                                 (returned[head] && fill_taken));

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
      issued <= '0;
      returned <= '0;
      head <= '0;
      issue <= '0;
      tail <= '0;
    end else begin
      for (int k = 0; k < num_slots; k++) begin
        if (miss_req.slot[k].en) begin
          busy[slot_ptr[k]] <= 1'b1;
          issued[slot_ptr[k]] <= 1'b0;
          returned[slot_ptr[k]] <= 1'b0;
        end
      end
      for (int i = 0; i < miss_depth; i++) begin
        if (data_match[i]) begin
          returned[i] <= 1'b1;
        end
      end
      if (accepted) begin
        issued[issue] <= 1'b1;
        issue <= issue + 1'b1;
      end
      if (retire) begin
        busy[head] <= 1'b0;
        head <= head + 1'b1;
      end
      tail <= tail + ptr_width'(push_count);
    end
  end

  always_ff @(posedge clock) begin
    for (int k = 0; k < num_slots; k++) begin
      if (miss_req.slot[k].en) begin
        entries[slot_ptr[k]].kind <= miss_req.slot[k].kind;
        entries[slot_ptr[k]].addr <= miss_req.slot[k].addr;
        entries[slot_ptr[k]].data <= miss_req.slot[k].data;
        entries[slot_ptr[k]].dirty <= miss_req.slot[k].dirty;
      end
    end
    if (accepted) begin
      entries[issue].tag <= mem_resp.response;
    end
    for (int i = 0; i < miss_depth; i++) begin
      // one-word line, store data covers the whole returned word
      if (data_match[i] && (entries[i].kind != miss_store)) begin
        entries[i].data <= mem_resp.data;
      end
    end
  end

endmodule

//--- logic/dcache_controller.sv
`timescale 1ns/10ps

module dcache_controller
  import cache_pkg::*, mem_bus_pkg::*;
#(
  parameter int num_sets = 8,
  parameter int miss_depth = 4
) (
  input  logic       clock,
  input  logic       reset,
  input  load_req_t  load_req,
  output load_resp_t load_resp,
  input  store_req_t store_req,
  output logic       store_accept,
  output mem_req_t   mem_req,
  input  mem_resp_t  mem_resp,
  input  logic       write_back,
  output logic       halt_pipeline
);

  localparam int slot_bits = $clog2(num_sets * num_ways);

  cache_addr_u          rd_addr;
  cache_addr_u          wr_addr;
  cache_addr_u          store_addr;
  cache_addr_u          sweep_addr;
  cache_addr_u          victim_addr;
  logic                 rd_hit;
  logic [63:0]          rd_data;
  logic                 wr_hit;
  logic                 wr_search;
  logic                 wr_en;
  logic                 wr_from_fill;
  logic                 wr_dirty;
  logic                 wr_valid;
  logic [63:0]          wr_data;
  logic [slot_bits-1:0] sweep_slot;
  cache_line_t          sweep_line;
  cache_line_t          victim;
  miss_req_t            miss_req;
  miss_req_t            next_miss_req;
  fill_t                fill;
  logic                 fill_taken;
  logic                 queue_ready;
  logic                 queue_empty;
  logic                 sweeping;
  logic                 sweep_step;
  logic                 sweep_last;
  logic                 store_miss;
  logic                 evict_en;
  // a load miss is queued once while its requester holds rd_en
  logic                 load_wait;

  assign rd_addr = {load_req.addr, 3'b000};
  assign store_addr = {store_req.addr, 3'b000};
  assign sweep_addr = {sweep_line.tag, sweep_slot[slot_bits-1:1], 3'b000};
  assign victim_addr = {victim.tag, wr_addr.f.index, 3'b000};

  // write port priority: sweep, then store, then fill
  always_comb begin
    wr_addr = fill.addr;
    wr_search = fill.en;
    wr_en = fill.en;
    wr_from_fill = 1'b1;
    wr_dirty = fill.dirty;
    wr_valid = 1'b1;
    wr_data = fill.data;
    if (sweeping) begin
      wr_addr = sweep_addr;
      wr_search = 1'b0;
      wr_en = sweep_step;
      wr_from_fill = 1'b0;
      wr_dirty = 1'b0;
      wr_valid = sweep_line.valid;
      wr_data = sweep_line.data;
    end else if (store_req.wr_en) begin
      wr_addr = store_addr;
      wr_search = 1'b1;
      wr_en = wr_hit;
      wr_from_fill = 1'b0;
      wr_dirty = 1'b1;
      wr_data = store_req.value;
    end
  end

  // a fill retires its own entry, so its evict always finds room
  assign fill_taken = wr_from_fill && wr_en;

  assign sweep_step = sweeping && queue_ready;

  assign store_miss = store_req.wr_en && !sweeping && !wr_hit && queue_ready;
  assign store_accept = store_req.wr_en && !sweeping && (wr_hit || queue_ready);

  assign load_resp.valid = rd_hit && queue_ready;
  assign load_resp.value = rd_data;

  assign evict_en = (fill_taken && !wr_hit && victim.valid && victim.dirty) ||
                    (sweep_step && sweep_line.valid && sweep_line.dirty);

  always_comb begin
    next_miss_req = '0;

    next_miss_req.slot[slot_load].en = load_req.rd_en && !rd_hit && queue_ready && !load_wait;
    next_miss_req.slot[slot_load].kind = miss_load;
    next_miss_req.slot[slot_load].addr = rd_addr;

    next_miss_req.slot[slot_store].en = store_miss;
    next_miss_req.slot[slot_store].kind = miss_store;
    next_miss_req.slot[slot_store].addr = store_addr;
    next_miss_req.slot[slot_store].data = store_req.value;
    next_miss_req.slot[slot_store].dirty = 1'b1;

    next_miss_req.slot[slot_evict].en = evict_en;
    next_miss_req.slot[slot_evict].kind = miss_evict;
    next_miss_req.slot[slot_evict].addr = sweeping ? sweep_addr : victim_addr;
    next_miss_req.slot[slot_evict].data = sweeping ? sweep_line.data : victim.data;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      miss_req <= '0;
      load_wait <= 1'b0;
    end else begin
      miss_req <= next_miss_req;
      if (load_resp.valid) begin
        load_wait <= 1'b0;
      end else if (next_miss_req.slot[slot_load].en) begin
        load_wait <= 1'b1;
      end
    end
  end

  dcache_array #(
    .num_sets(num_sets)
  ) u_array (
    .clock       (clock),
    .reset       (reset),
    .rd_addr     (rd_addr),
    .rd_search   (load_req.rd_en),
    .rd_hit      (rd_hit),
    .rd_data     (rd_data),
    .wr_addr     (wr_addr),
    .wr_search   (wr_search),
    .wr_en       (wr_en),
    .wr_from_fill(wr_from_fill),
    .wr_dirty    (wr_dirty),
    .wr_valid    (wr_valid),
    .wr_data     (wr_data),
    .wr_hit      (wr_hit),
    .sweep_slot  (sweep_slot),
    .sweep_line  (sweep_line),
    .victim      (victim)
  );

  miss_queue #(
    .miss_depth(miss_depth)
  ) u_miss_queue (
    .clock      (clock),
    .reset      (reset),
    .miss_req   (miss_req),
    .queue_ready(queue_ready),
    .queue_empty(queue_empty),
    .fill       (fill),
    .fill_taken (fill_taken),
    .mem_req    (mem_req),
    .mem_resp   (mem_resp)
  );

  flush_sequencer u_flush_sequencer (
    .clock        (clock),
    .reset        (reset),
    .write_back   (write_back),
    .queue_empty  (queue_empty),
    .sweep_last   (sweep_last),
    .sweep_step   (sweep_step),
    .sweeping     (sweeping),
    .halt_pipeline(halt_pipeline)
  );

  flush_counter #(
    .num_sets(num_sets)
  ) u_flush_counter (
    .clock(clock),
    .reset(reset),
    .start(write_back && !sweeping),
    .step (sweep_step),
    .slot (sweep_slot),
    .last (sweep_last)
  );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int period_ns = 10,
  parameter int reset_cycles = 8
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period_ns / 2) clock = ~clock;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

//--- sim/dcache_checker.sv
`timescale 1ns/10ps

module dcache_checker
  import cache_pkg::*, mem_bus_pkg::*;
(
  input logic       clock,
  input logic       reset,
  input load_req_t  load_req,
  input load_resp_t load_resp,
  input mem_req_t   mem_req,
  input mem_resp_t  mem_resp,
  input logic       halt_pipeline
);

  property reset_state_p;
    @(posedge clock) reset |=> (mem_req.command == bus_none) && !halt_pipeline &&
                               !load_resp.valid;
  endproperty

  // memory back-pressure keeps the same command on the bus
  property refused_held_p;
    @(posedge clock) disable iff (reset)
      (mem_req.command != bus_none && mem_resp.response == '0) |=> $stable(mem_req);
  endproperty

  property load_valid_p;
    @(posedge clock) disable iff (reset)
      load_resp.valid |-> load_req.rd_en;
  endproperty

  // halt stays up and the bus stays idle from then on
  property quiet_after_halt_p;
    @(posedge clock) disable iff (reset)
      halt_pipeline |=> halt_pipeline && (mem_req.command == bus_none);
  endproperty

  assert property (reset_state_p)
    else $error("bus command, halt_pipeline or load valid not clear after reset");

  assert property (refused_held_p)
    else $error("refused memory command changed before it was accepted");

  assert property (load_valid_p)
    else $error("load valid raised without rd_en");

  assert property (quiet_after_halt_p)
    else $error("halt_pipeline dropped or a memory command followed it");

endmodule

//--- sim/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb
  import cache_pkg::*, mem_bus_pkg::*;
();

  localparam int mem_size = 8192;
  localparam int timeout_cycles = 20000;
  localparam int return_delay = 6;

  logic       clock;
  logic       reset;
  load_req_t  load_req;
  load_resp_t load_resp;
  store_req_t store_req;
  logic       store_accept;
  mem_req_t   mem_req;
  mem_resp_t  mem_resp;
  logic       write_back;
  logic       halt_pipeline;

  logic [63:0] memory [mem_size];
  logic [63:0] ref_mem [mem_size];
  logic [3:0]  ret_tag_q [$];
  logic [63:0] ret_data_q [$];
  int          ret_due_q [$];
  logic [3:0]  next_tag;
  int          seed;
  int          refuse_pct;
  int          error_count;
  int          check_count;
  int          cycle_count;
  int          evict_count;
  int          stall_count;

  tb_clock_gen u_clock_gen (
    .clock(clock),
    .reset(reset)
  );

  dcache_controller u_dut (
    .clock        (clock),
    .reset        (reset),
    .load_req     (load_req),
    .load_resp    (load_resp),
    .store_req    (store_req),
    .store_accept (store_accept),
    .mem_req      (mem_req),
    .mem_resp     (mem_resp),
    .write_back   (write_back),
    .halt_pipeline(halt_pipeline)
  );

  bind dcache_controller dcache_checker u_checker (
    .clock        (clock),
    .reset        (reset),
    .load_req     (load_req),
    .load_resp    (load_resp),
    .mem_req      (mem_req),
    .mem_resp     (mem_resp),
    .halt_pipeline(halt_pipeline)
  );

  // every bit group follows the word address
  function automatic logic [63:0] addr_pattern(input logic [12:0] wa);
    return {3'b101, wa, 3'b011, ~wa, wa ^ 13'h1abc, 3'b110, wa[5:0], wa[12:3]};
  endfunction

  function automatic logic [12:0] pick_addr(input logic [12:0] base, input int span);
    return base + 13'($unsigned($random(seed)) % span);
  endfunction

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // memory model, answers on the falling edge
  always @(negedge clock) begin : memory_model
    int roll;
    mem_resp = '0;
    if (!reset) begin
      if (ret_due_q.size() > 0 && ret_due_q[0] <= cycle_count) begin
        mem_resp.data_tag = ret_tag_q.pop_front();
        mem_resp.data = ret_data_q.pop_front();
        void'(ret_due_q.pop_front());
      end
      if (mem_req.command != bus_none) begin
        roll = int'($unsigned($random(seed)) % 100);
        if (roll >= refuse_pct) begin
          mem_resp.response = next_tag;
          if (mem_req.command == bus_store) begin
            memory[mem_req.addr[15:3]] = mem_req.data;
            evict_count++;
          end else begin
            ret_tag_q.push_back(next_tag);
            ret_data_q.push_back(memory[mem_req.addr[15:3]]);
            ret_due_q.push_back(cycle_count + return_delay);
          end
          next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
      end
    end
  end

  task automatic report_mismatch(input string what, input logic [12:0] wa,
                                 input logic [63:0] got, input logic [63:0] expected);
    error_count++;
    $display("FAIL t=%0t %s at word 0x%h: got %h expected %h", $time, what, wa, got,
             expected);
  endtask

  // entered and left on a falling edge
  task automatic store_word(input logic [12:0] wa, input logic [63:0] value);
    bit done;
    done = 1'b0;
    while (!done) begin
      store_req.wr_en = 1'b1;
      store_req.addr = wa;
      store_req.value = value;
      @(posedge clock);
      if (store_accept) begin
        done = 1'b1;
        ref_mem[wa] = value;
      end
      @(negedge clock);
      if (!done) begin
        // a returned fill only reaches the array while no store is pending
        stall_count++;
        store_req.wr_en = 1'b0;
        @(negedge clock);
      end
    end
    store_req.wr_en = 1'b0;
  endtask

  task automatic load_word(input logic [12:0] wa, output logic [63:0] value,
                           output int latency);
    bit got;
    got = 1'b0;
    latency = 0;
    load_req.rd_en = 1'b1;
    load_req.addr = wa;
    while (!got) begin
      @(posedge clock);
      if (load_resp.valid) begin
        got = 1'b1;
        value = load_resp.value;
      end else begin
        latency++;
      end
      @(negedge clock);
    end
    load_req.rd_en = 1'b0;
  endtask

  task automatic check_load(input logic [12:0] wa);
    logic [63:0] value;
    int latency;
    load_word(wa, value, latency);
    check_count++;
    assert (value == ref_mem[wa])
      else report_mismatch("load", wa, value, ref_mem[wa]);
  endtask

  initial begin : stimulus
    logic [63:0] value;
    int latency;
    int evicts_before;
    int stalls_before;
    logic [12:0] wa;
    seed = 6766;
    refuse_pct = 25;
    next_tag = 4'd1;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    evict_count = 0;
    stall_count = 0;
    load_req = '0;
    store_req = '0;
    write_back = 1'b0;
    mem_resp = '0;
    for (int i = 0; i < mem_size; i++) begin
      memory[i] = addr_pattern(13'(i));
      ref_mem[i] = addr_pattern(13'(i));
    end
    wait (reset == 1'b0);
    @(negedge clock);

    // cold miss, then a same-cycle hit
    load_word(13'h0123, value, latency);
    check_count++;
    assert (value == addr_pattern(13'h0123) && latency > 0)
      else report_mismatch("cold load", 13'h0123, value, addr_pattern(13'h0123));
    load_word(13'h0123, value, latency);
    check_count++;
    assert (value == addr_pattern(13'h0123) && latency == 0)
      else report_mismatch("hit load", 13'h0123, value, addr_pattern(13'h0123));

    // store hit is accepted in its own cycle, then a store miss
    stalls_before = stall_count;
    store_word(13'h0123, 64'h1111_2222_3333_4444);
    check_count++;
    assert (stall_count == stalls_before)
      else begin
        error_count++;
        $display("FAIL t=%0t store hit at word 0x0123 was not accepted at once", $time);
      end
    check_load(13'h0123);
    store_word(13'h0456, 64'h5555_6666_7777_8888);
    check_load(13'h0456);

    // three tags in set 5 push one dirty line out
    evicts_before = evict_count;
    store_word(13'h0105, 64'ha0a0_0105_0000_0001);
    store_word(13'h010d, 64'ha0a0_010d_0000_0002);
    store_word(13'h0115, 64'ha0a0_0115_0000_0003);
    check_load(13'h0105);
    check_load(13'h010d);
    check_load(13'h0115);
    check_count++;
    assert (evict_count > evicts_before && memory[13'h0105] == ref_mem[13'h0105])
      else report_mismatch("evicted word", 13'h0105, memory[13'h0105], ref_mem[13'h0105]);

    // heavy refusal with a burst of store misses
    refuse_pct = 75;
    stall_count = 0;
    for (int i = 0; i < 40; i++) begin
      wa = pick_addr(13'h0200, 64);
      store_word(wa, {$random(seed), $random(seed)});
    end
    check_count++;
    assert (stall_count > 0)
      else begin
        error_count++;
        $display("FAIL t=%0t no store stalled under memory back-pressure", $time);
      end
    for (int i = 0; i < 64; i++) begin
      check_load(13'h0200 + 13'(i));
    end
    refuse_pct = 25;

    // mixed traffic, then the end-of-program flush
    for (int i = 0; i < 150; i++) begin
      wa = pick_addr(13'h0000, 128);
      if ($random(seed) % 2 == 0) begin
        store_word(wa, {$random(seed), $random(seed)});
      end else begin
        check_load(wa);
      end
    end
    write_back = 1'b1;
    @(negedge clock);
    write_back = 1'b0;
    while (!halt_pipeline) begin
      @(negedge clock);
    end
    repeat (20) @(negedge clock);
    check_count++;
    assert (halt_pipeline)
      else begin
        error_count++;
        $display("FAIL t=%0t halt_pipeline dropped after the flush", $time);
      end
    for (int i = 0; i < mem_size; i++) begin
      check_count++;
      assert (memory[i] == ref_mem[i])
        else report_mismatch("memory after flush", 13'(i), memory[i], ref_mem[i]);
    end

    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
logic/cache_pkg.sv
logic/mem_bus_pkg.sv
logic/dcache_array.sv
logic/flush_counter.sv
logic/flush_sequencer.sv
logic/miss_queue.sv
logic/dcache_controller.sv
sim/tb_clock_gen.sv
sim/dcache_checker.sv
sim/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module dcache_tb \
  -o dcache_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/dcache_sim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no pass result in sim.log"; exit 1; }
exit 0
